/* design/dwnld_packer.sv */
// The host cannot be stalled so a record refused by a full FIFO is lost and sets dwnld_ovf
`timescale 1ns/1ps
`include "rumble_defs.svh"

module dwnld_packer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        downloading,
    input  logic [`RUMBLE_IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]                  ioctl_dout,
    input  logic                        ioctl_wr,
    output logic                        dwnld_ovf,
    prog_if.src                         out
);
    import rumble_pkg::*;

    region_e                     region;
    logic [`RUMBLE_IOCTL_AW-1:0] base;
    logic [`RUMBLE_IOCTL_AW-1:0] offset;
    logic [1:0]                  bank;
    logic                        take;
    logic                        dwnld_q;

    // Address decode into ROM regions
    always_comb begin
        if (ioctl_addr < `RUMBLE_SND_START) begin
            region = REGION_MAIN;
        end else if (ioctl_addr < `RUMBLE_GFX_START) begin
            region = REGION_SND;
        end else if (ioctl_addr < `RUMBLE_ROM_END) begin
            region = REGION_GFX;
        end else begin
            region = REGION_NONE;
        end
    end

    always_comb begin
        case (region)
            REGION_SND: begin
                base = `RUMBLE_SND_START;
                bank = 2'd1;
            end
            REGION_GFX: begin
                base = `RUMBLE_GFX_START;
                bank = 2'd2;
            end
            default: begin
                base = '0;
                bank = 2'd0;
            end
        endcase
    end

    assign offset = ioctl_addr - base;
    assign take   = ioctl_wr && downloading && (region != REGION_NONE);

    // Record is offered for exactly one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= take;
        end
    end

    // Byte goes on both lanes, the mask picks the lane from address bit 0
    always_ff @(posedge clk) begin
        if (take) begin
            out.rec.addr <= offset[`RUMBLE_PROG_AW:1];
            out.rec.data <= {ioctl_dout, ioctl_dout};
            out.rec.mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            out.rec.ba   <= bank;
        end
    end

    // Sticky drop flag, cleared when a new download starts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dwnld_q   <= 1'b0;
            dwnld_ovf <= 1'b0;
        end else begin
            dwnld_q <= downloading;
            if (downloading && !dwnld_q) begin
                dwnld_ovf <= 1'b0;
            end else if (out.valid && !out.ready) begin
                dwnld_ovf <= 1'b1;
            end
        end
    end

endmodule

/* design/prog_fifo.sv */
// Show-ahead buffer, ready is low whenever full even if the head is leaving that cycle
`timescale 1ns/1ps
`include "rumble_defs.svh"

module prog_fifo #(
    parameter int DEPTH = `RUMBLE_FIFO_DEPTH
) (
    input  logic clk,
    input  logic rst_n,
    prog_if.dst  in,
    prog_if.src  out,
    output logic empty
);
    import rumble_pkg::*;

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    prog_rec_t     mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          full;
    logic          push;
    logic          pop;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        if (ptr == PW'(DEPTH - 1)) begin
            next_ptr = '0;
        end else begin
            next_ptr = ptr + 1'b1;
        end
    endfunction

    assign empty     = (count == '0);
    assign full      = (count == CW'(DEPTH));
    assign in.ready  = !full;
    assign out.valid = !empty;
    // Head entry always visible
    assign out.rec   = mem[rd_ptr];
    assign push      = in.valid && in.ready;
    assign pop       = out.valid && out.ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in.rec;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/prog_if.sv */
// A record moves on a rising clk edge only when valid and ready are both high
`timescale 1ns/1ps

interface prog_if;
    import rumble_pkg::*;

    prog_rec_t rec;
    logic      valid;
    logic      ready;

    // Producer side
    modport src (
        output rec,
        output valid,
        input  ready
    );

    // Consumer side
    modport dst (
        input  rec,
        input  valid,
        output ready
    );

endinterface

/* design/prog_writer.sv */
// SDRAM must drop prog_rdy after prog_we falls or the writer waits in WR_RELEASE forever
`timescale 1ns/1ps

module prog_writer (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    input  logic        fifo_empty,
    prog_if.dst         in,
    output logic [21:0] prog_addr,
    output logic [15:0] prog_data,
    output logic [1:0]  prog_mask,
    output logic [1:0]  prog_ba,
    output logic        prog_we,
    input  logic        prog_rdy,
    output logic        dwnld_busy
);
    import rumble_pkg::*;

    wr_state_e state;
    logic      pop;

    // Only take a record between write cycles
    assign in.ready = (state == WR_IDLE);
    assign pop      = in.valid && in.ready;

    // Fields stay stable for the whole request
    always_ff @(posedge clk) begin
        if (pop) begin
            prog_addr <= in.rec.addr;
            prog_data <= in.rec.data;
            prog_mask <= in.rec.mask;
            prog_ba   <= in.rec.ba;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= WR_IDLE;
            prog_we <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (pop) begin
                        prog_we <= 1'b1;
                        state   <= WR_REQ;
                    end
                end
                // Hold the request until the SDRAM acknowledges
                WR_REQ: begin
                    if (prog_rdy) begin
                        prog_we <= 1'b0;
                        state   <= WR_RELEASE;
                    end
                end
                // Write is complete once the acknowledge falls
                WR_RELEASE: begin
                    if (!prog_rdy) begin
                        state <= WR_IDLE;
                    end
                end
                default: begin
                    prog_we <= 1'b0;
                    state   <= WR_IDLE;
                end
            endcase
        end
    end

    // Busy covers the host transfer, queued records and the write in progress
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dwnld_busy <= 1'b0;
        end else begin
            dwnld_busy <= downloading || !fifo_empty || (state != WR_IDLE);
        end
    end

endmodule

/* design/rumble_defs.svh */
// Region boundaries are download byte addresses and must stay ascending and even aligned
`ifndef RUMBLE_DEFS_SVH
`define RUMBLE_DEFS_SVH

// Host download byte address and SDRAM word address widths
`define RUMBLE_IOCTL_AW   25
`define RUMBLE_PROG_AW    22

// ROM layout inside the download stream
// Main CPU ROM starts at zero and goes to bank 0
`define RUMBLE_SND_START  25'h004_0000
// Sound CPU ROM goes to bank 1
`define RUMBLE_GFX_START  25'h004_8000
// Graphics ROM goes to bank 2, anything past the end is ignored
`define RUMBLE_ROM_END    25'h00C_8000

// Pending SDRAM writes between packer and writer
`define RUMBLE_FIFO_DEPTH 4

`endif

/* design/rumble_game.sv */
// Only the ROM download path is present and prog_we/prog_rdy follow a four-phase handshake
`timescale 1ns/1ps
`include "rumble_defs.svh"

module rumble_game (
    input  logic                        clk,
    input  logic                        rst_n,
    // ROM download from the host
    input  logic                        downloading,
    input  logic [`RUMBLE_IOCTL_AW-1:0] ioctl_addr,
    input  logic [7:0]                  ioctl_dout,
    input  logic                        ioctl_wr,
    // SDRAM programming port
    output logic [21:0]                 prog_addr,
    output logic [15:0]                 prog_data,
    output logic [1:0]                  prog_mask,
    output logic [1:0]                  prog_ba,
    output logic                        prog_we,
    input  logic                        prog_rdy,
    // Status
    output logic                        dwnld_busy,
    output logic                        dwnld_ovf
);

    logic fifo_empty;

    prog_if pk2fifo ();
    prog_if fifo2wr ();

    dwnld_packer u_packer (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .dwnld_ovf   ( dwnld_ovf   ),
        .out         ( pk2fifo     )
    );

    prog_fifo #(
        .DEPTH ( `RUMBLE_FIFO_DEPTH )
    ) u_fifo (
        .clk   ( clk        ),
        .rst_n ( rst_n      ),
        .in    ( pk2fifo    ),
        .out   ( fifo2wr    ),
        .empty ( fifo_empty )
    );

    prog_writer u_writer (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .fifo_empty  ( fifo_empty  ),
        .in          ( fifo2wr     ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_ba     ( prog_ba     ),
        .prog_we     ( prog_we     ),
        .prog_rdy    ( prog_rdy    ),
        .dwnld_busy  ( dwnld_busy  )
    );

endmodule

/* design/rumble_pkg.sv */
// Record layout is shared by packer, FIFO and writer so field order must not change alone
`include "rumble_defs.svh"

package rumble_pkg;

    // ROM region of one download byte
    typedef enum logic [1:0] {
        REGION_MAIN = 2'd0,
        REGION_SND  = 2'd1,
        REGION_GFX  = 2'd2,
        REGION_NONE = 2'd3
    } region_e;

    // Four-phase write cycle on the SDRAM programming port
    typedef enum logic [1:0] {
        WR_IDLE    = 2'd0,
        WR_REQ     = 2'd1,
        WR_RELEASE = 2'd2
    } wr_state_e;

    // One SDRAM write, mask bits are active low
    typedef struct packed {
        logic [`RUMBLE_PROG_AW-1:0] addr;
        logic [15:0]                data;
        logic [1:0]                 mask;
        logic [1:0]                 ba;
    } prog_rec_t;

endpackage

/* dv/tb_rumble_game.sv */
// SDRAM model answers one write at a time and the overflow burst assumes the default FIFO depth
`timescale 1ns/1ps
`include "rumble_defs.svh"

module tb_rumble_game;
    import rumble_pkg::*;

    typedef logic [`RUMBLE_IOCTL_AW-1:0] baddr_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        downloading;
    baddr_t      ioctl_addr;
    logic [7:0]  ioctl_dout;
    logic        ioctl_wr;
    logic [21:0] prog_addr;
    logic [15:0] prog_data;
    logic [1:0]  prog_mask;
    logic [1:0]  prog_ba;
    logic        prog_we;
    logic        prog_rdy = 1'b0;
    logic        dwnld_busy;
    logic        dwnld_ovf;

    logic [31:0] lfsr = 32'hd7df;
    int          fixed_delay = 0;
    int          rdy_wait = 0;
    logic        we_prev = 1'b0;
    logic        rdy_prev = 1'b0;
    prog_rec_t   seen;
    prog_rec_t   exp_q[$];
    region_e     exp_region_q[$];
    prog_rec_t   got_q[$];

    rumble_game rumble_game_i (.*);

    always #50 clk = ~clk;

    // Fibonacci taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Three fresh bits give 1 to 8 cycles
    task automatic draw_delay(output int d);
        logic [2:0] bits;
        for (int i = 0; i < 3; i++) begin
            lfsr    = lfsr_next(lfsr);
            bits[i] = lfsr[0];
        end
        d = int'(bits) + 1;
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_rec(input string name, input prog_rec_t got, input prog_rec_t exp);
        if (got.addr !== exp.addr)
            fail_run($sformatf("Error: %s prog_addr got %h expected %h",
                               name, got.addr, exp.addr));
        if (got.data !== exp.data)
            fail_run($sformatf("Error: %s prog_data got %h expected %h",
                               name, got.data, exp.data));
        if (got.mask !== exp.mask)
            fail_run($sformatf("Error: %s prog_mask got %h expected %h",
                               name, got.mask, exp.mask));
        if (got.ba !== exp.ba)
            fail_run($sformatf("Error: %s prog_ba got %h expected %h", name, got.ba, exp.ba));
    endtask

    // SDRAM side of the four-phase handshake
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_rdy <= 1'b0;
            rdy_wait = 0;
        end else if (prog_we && !prog_rdy) begin
            if (rdy_wait == 0) begin
                if (fixed_delay != 0)
                    rdy_wait = fixed_delay;
                else
                    draw_delay(rdy_wait);
            end
            rdy_wait = rdy_wait - 1;
            if (rdy_wait == 0) begin
                seen.addr = prog_addr;
                seen.data = prog_data;
                seen.mask = prog_mask;
                seen.ba   = prog_ba;
                got_q.push_back(seen);
                prog_rdy <= 1'b1;
            end
        end else if (!prog_we && prog_rdy) begin
            prog_rdy <= 1'b0;
        end
    end

    // A new request must wait until the previous acknowledge was seen low
    always @(negedge clk) begin
        if (rst_n && prog_we && !we_prev)
            check_bit("prog_rdy before prog_we rise", rdy_prev, 1'b0);
        we_prev  = prog_we;
        rdy_prev = prog_rdy;
    end

    function automatic region_e region_of(input baddr_t a);
        if (a >= `RUMBLE_ROM_END)
            return REGION_NONE;
        if (a >= `RUMBLE_GFX_START)
            return REGION_GFX;
        if (a >= `RUMBLE_SND_START)
            return REGION_SND;
        return REGION_MAIN;
    endfunction

    // Expected write straight from the ROM map
    function automatic prog_rec_t expect_rec(input baddr_t a, input logic [7:0] d);
        prog_rec_t r;
        baddr_t    off;
        off  = a;
        r.ba = 2'd0;
        if (region_of(a) == REGION_SND) begin
            off  = a - `RUMBLE_SND_START;
            r.ba = 2'd1;
        end else if (region_of(a) == REGION_GFX) begin
            off  = a - `RUMBLE_GFX_START;
            r.ba = 2'd2;
        end
        r.addr = off[`RUMBLE_PROG_AW:1];
        r.data = {d, d};
        // Mask is active low and odd bytes land in the high lane
        r.mask = a[0] ? 2'b01 : 2'b10;
        return r;
    endfunction

    task automatic set_downloading(input logic level);
        @(posedge clk);
        downloading <= level;
    endtask

    task automatic send_byte(input baddr_t a);
        @(posedge clk);
        ioctl_addr <= a;
        ioctl_dout <= a[7:0] ^ 8'h5a;
        ioctl_wr   <= 1'b1;
        if (region_of(a) != REGION_NONE) begin
            exp_q.push_back(expect_rec(a, a[7:0] ^ 8'h5a));
            exp_region_q.push_back(region_of(a));
        end
    endtask

    task automatic end_burst();
        @(posedge clk);
        ioctl_wr <= 1'b0;
    endtask

    // Quiet window is longer than the packer to writer latency
    task automatic wait_idle(input int limit);
        int quiet;
        quiet = 0;
        for (int n = 0; n < limit && quiet < 6; n++) begin
            @(negedge clk);
            quiet = (prog_we || prog_rdy) ? 0 : quiet + 1;
        end
        if (quiet < 6)
            fail_run("Timeout: SDRAM write activity did not settle");
    endtask

    task automatic send_paced(input baddr_t a);
        send_byte(a);
        end_burst();
        wait_idle(200);
    endtask

    task automatic clear_queues();
        got_q.delete();
        exp_q.delete();
        exp_region_q.delete();
    endtask

    task automatic compare_writes(input string test);
        if (got_q.size() != exp_q.size())
            fail_run($sformatf("%s: %0d SDRAM writes expected but %0d seen",
                               test, exp_q.size(), got_q.size()));
        foreach (exp_q[i])
            check_rec($sformatf("%s %s write %0d", test, exp_region_q[i].name(), i),
                      got_q[i], exp_q[i]);
        clear_queues();
    endtask

    task automatic test_reset();
        @(negedge clk);
        check_bit("prog_we", prog_we, 1'b0);
        check_bit("dwnld_busy", dwnld_busy, 1'b0);
        check_bit("dwnld_ovf", dwnld_ovf, 1'b0);
    endtask

    task automatic test_main_region();
        set_downloading(1'b1);
        send_paced(25'h000_0000);
        send_paced(25'h000_0001);
        send_paced(25'h000_1234);
        send_paced(25'h000_1235);
        send_paced(25'h002_0001);
        compare_writes("test_main_region");
    endtask

    task automatic test_region_map();
        send_paced(baddr_t'(`RUMBLE_SND_START - 2));
        send_paced(baddr_t'(`RUMBLE_SND_START - 1));
        send_paced(`RUMBLE_SND_START);
        send_paced(baddr_t'(`RUMBLE_SND_START + 1));
        send_paced(baddr_t'(`RUMBLE_GFX_START - 1));
        send_paced(`RUMBLE_GFX_START);
        send_paced(baddr_t'(`RUMBLE_ROM_END - 1));
        compare_writes("test_region_map");
    endtask

    task automatic test_out_of_range();
        send_paced(25'h000_0100);
        send_paced(`RUMBLE_ROM_END);
        send_paced(25'h004_0010);
        send_paced(baddr_t'(`RUMBLE_ROM_END + 5));
        send_paced(25'h1ff_ffff);
        send_paced(25'h004_8003);
        compare_writes("test_out_of_range");
    endtask

    task automatic test_overflow();
        int j;
        int n;
        fixed_delay = 40;
        for (int i = 0; i < 12; i++)
            send_byte(baddr_t'(25'h200 + i));
        end_burst();
        for (n = 0; n < 50 && !dwnld_ovf; n++)
            @(negedge clk);
        if (!dwnld_ovf)
            fail_run("Timeout: dwnld_ovf did not rise while bytes were dropped");
        wait_idle(1000);
        // Survivors must appear in the order they were sent
        j = 0;
        foreach (got_q[i]) begin
            while (j < exp_q.size() && got_q[i] !== exp_q[j])
                j++;
            if (j == exp_q.size())
                fail_run($sformatf("test_overflow: write %0d is out of order or unknown", i));
            j++;
        end
        if (got_q.size() == 0 || got_q.size() == exp_q.size())
            fail_run("test_overflow: a full FIFO did not drop part of the burst");
        // Flag is sticky through the whole drain
        check_bit("dwnld_ovf", dwnld_ovf, 1'b1);
        clear_queues();
        fixed_delay = 0;
        set_downloading(1'b0);
        set_downloading(1'b1);
        for (n = 0; n < 10 && dwnld_ovf; n++)
            @(negedge clk);
        if (dwnld_ovf)
            fail_run("Timeout: dwnld_ovf did not clear after downloading rose again");
    endtask

    task automatic test_busy();
        int n;
        for (int i = 0; i < 4; i++)
            send_byte(baddr_t'(`RUMBLE_GFX_START + 2 * i));
        end_burst();
        set_downloading(1'b0);
        // Busy holds until the last acknowledge has fallen
        for (n = 0; n < 400; n++) begin
            @(negedge clk);
            if (got_q.size() == exp_q.size() && !prog_we && !prog_rdy)
                break;
            check_bit("dwnld_busy", dwnld_busy, 1'b1);
        end
        if (n == 400)
            fail_run("Timeout: the writes of test_busy did not complete");
        for (n = 0; n < 8 && dwnld_busy; n++)
            @(negedge clk);
        if (dwnld_busy)
            fail_run("Timeout: dwnld_busy did not fall after the last write");
        compare_writes("test_busy");
    endtask

    initial begin
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_main_region();
        test_region_map();
        test_out_of_range();
        test_overflow();
        test_busy();
        $display("Done: no errors");
        $finish;
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the ROM download testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_rumble_game \
    -f vlog.f \
    -o sim_rumble

./obj_dir/sim_rumble | tee sim.log

if grep -q "Done: no errors" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

/* vlog.f */
+incdir+design
design/rumble_pkg.sv
design/prog_if.sv
design/dwnld_packer.sv
design/prog_fifo.sv
design/prog_writer.sv
design/rumble_game.sv
dv/tb_rumble_game.sv
